/* include/mmu_cfg.svh */
// Sizing for the address translation unit
// TLB geometry, page number widths and queue credit depths

`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// TLB slots and index width
`define TLB_ENTRIES 4
`define TLB_INDEX_W 2

// Sv32 page numbers
`define VPN_W 20
`define PPN_W 22

// Queue depths, also the starting credit count on each channel
`define REQ_DEPTH 4
`define RSP_DEPTH 4

`endif

/* hw/MmuTypes.sv */
// Shared types for the translation unit
// Privilege, access type, PTE flags, TLB entry and queue payloads

`include "mmu_cfg.svh"

package MmuTypes;

    typedef logic [`VPN_W-1:0] Vpn;
    typedef logic [`PPN_W-1:0] Ppn;
    typedef logic [`TLB_INDEX_W-1:0] TlbIndex;

    typedef enum logic [1:0] {
        PrivUser       = 2'd0,
        PrivSupervisor = 2'd1,
        PrivMachine    = 2'd3
    } Privilege;

    typedef enum logic [1:0] {
        AccInstr = 2'd0,
        AccLoad  = 2'd1,
        AccStore = 2'd2
    } AccessType;

    typedef struct packed {
        logic read;
        logic write;
        logic execute;
        logic user;
        logic dirty;
    } PteFlags;

    typedef struct packed {
        logic    valid;
        logic    fault;
        PteFlags flags;
        Ppn      ppn;
    } TlbEntry;

    typedef struct packed {
        Vpn        vpn;
        AccessType access;
    } TranslateReq;

    typedef struct packed {
        Ppn   ppn;
        logic fault;
    } TranslateRsp;

endpackage

/* hw/CreditFifo.sv */
// Credit-based queue with a type-parameterised payload
// Returns one upstream credit per pop, spends downstream credits to send

`timescale 1ns/10ps

module CreditFifo #(
    parameter type payload_t = logic,
    parameter int DEPTH = 4,
    parameter int OUT_CREDITS = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     inValid,
    input  payload_t inData,
    output logic     inCredit,
    output logic     full,
    output logic     outValid,
    output payload_t outData,
    input  logic     outCredit,
    input  logic     popReady
);
    localparam int PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CntW = $clog2(DEPTH + 1);
    localparam int CredW = $clog2(OUT_CREDITS + 1);

    payload_t mem [DEPTH];
    logic [PtrW-1:0] head;
    logic [PtrW-1:0] tail;
    logic [CntW-1:0] count;
    logic [CredW-1:0] credits;
    logic push;
    logic pop;

    function automatic logic [PtrW-1:0] advance(logic [PtrW-1:0] ptr);
        if (ptr == PtrW'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + PtrW'(1);
    endfunction

    assign full = (count == CntW'(DEPTH));
    assign push = inValid && !full;

    // Head leaves only while the downstream side still has room
    assign outValid = (count != '0) && (credits != '0);
    assign pop = outValid && popReady;
    assign outData = mem[head];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= inData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            credits <= CredW'(OUT_CREDITS);
            inCredit <= 1'b0;
        end else begin
            if (push) begin
                tail <= advance(tail);
            end
            if (pop) begin
                head <= advance(head);
            end
            case ({push, pop})
                2'b10: count <= count + CntW'(1);
                2'b01: count <= count - CntW'(1);
                default: count <= count;
            endcase
            // Spend one per send, regain one per returned pulse
            case ({pop, outCredit})
                2'b10: credits <= credits - CredW'(1);
                2'b01: credits <= credits + CredW'(1);
                default: credits <= credits;
            endcase
            inCredit <= pop;
        end
    end

endmodule

/* hw/TlbEntrySlot.sv */
// Single fully associative TLB slot
// Holds a VPN key and its entry, compares against the lookup key

`timescale 1ns/10ps

module TlbEntrySlot import MmuTypes::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    input  logic    we,
    input  Vpn      wKey,
    input  TlbEntry wEntry,
    input  Vpn      lookupKey,
    output logic    match,
    output TlbEntry entry
);
    logic    slotValid;
    Vpn      key;
    TlbEntry stored;

    // Valid lives apart from the payload so that flush is cheap
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            slotValid <= 1'b0;
        end else if (we) begin
            slotValid <= wEntry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            key <= wKey;
            stored <= wEntry;
        end
    end

    always_comb begin
        entry = stored;
        entry.valid = slotValid;
    end

    assign match = slotValid && (key == lookupKey);

endmodule

/* hw/TlbFill.sv */
// TLB refill unit
// Round-robin victim pointer, per-slot write enables, in-place replace

`timescale 1ns/10ps

`include "mmu_cfg.svh"

module TlbFill import MmuTypes::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    refill,
    input  logic                    replace,
    input  TlbIndex                 replaceIndex,
    input  Vpn                      refillKey,
    input  TlbEntry                 refillEntry,
    output logic [`TLB_ENTRIES-1:0] slotWe,
    output Vpn                      wKey,
    output TlbEntry                 wEntry
);
    TlbIndex victim;
    TlbIndex target;
    logic    pending;
    logic    pendingReplace;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            victim <= '0;
        end else begin
            pending <= refill;
            // Victim moves with the write itself, never on a replace
            if (pending && !pendingReplace) begin
                if (victim == TlbIndex'(`TLB_ENTRIES - 1)) begin
                    victim <= '0;
                end else begin
                    victim <= victim + TlbIndex'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill) begin
            target <= replace ? replaceIndex : victim;
            pendingReplace <= replace;
            wKey <= refillKey;
            wEntry <= refillEntry;
        end
    end

    always_comb begin
        slotWe = '0;
        if (pending) begin
            slotWe[target] = 1'b1;
        end
    end

endmodule

/* hw/TlbLookup.sv */
// Combinational TLB lookup
// Hit selection, Sv32 permission faults, dirty-update detection, bypass

`timescale 1ns/10ps

`include "mmu_cfg.svh"

module TlbLookup import MmuTypes::*; (
    input  logic [`TLB_ENTRIES-1:0] match,
    input  TlbEntry                 entries [`TLB_ENTRIES],
    input  Vpn                      vpn,
    input  AccessType               access,
    input  Privilege                priv,
    input  logic                    satpSv32,
    input  logic                    sum,
    input  logic                    mxr,
    output logic                    hit,
    output logic                    needsUpdate,
    output logic                    fault,
    output Ppn                      ppn,
    output TlbIndex                 hitIndex
);
    logic    found;
    logic    selFault;
    TlbEntry selEntry;
    TlbIndex selIndex;

    function automatic logic isFault(TlbEntry e, AccessType acc, Privilege p,
                                     logic s, logic m);
        logic bad;
        bad = e.fault;
        if (p == PrivSupervisor && !s && e.flags.user) begin
            bad = 1'b1;
        end
        if (p == PrivUser && !e.flags.user) begin
            bad = 1'b1;
        end
        case (acc)
            AccInstr: bad = bad || !e.flags.execute;
            // mxr makes executable pages readable
            AccLoad: bad = bad || (!e.flags.read && !(m && e.flags.execute));
            AccStore: bad = bad || !e.flags.write;
            default: bad = 1'b1;
        endcase
        return bad;
    endfunction

    // Lowest matching slot wins, only one should match anyway
    always_comb begin
        found = 1'b0;
        selEntry = '0;
        selIndex = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (match[i] && !found) begin
                found = 1'b1;
                selEntry = entries[i];
                selIndex = TlbIndex'(i);
            end
        end
    end

    assign selFault = isFault(selEntry, access, priv, sum, mxr);
    assign hitIndex = selIndex;

    always_comb begin
        if (priv == PrivMachine || !satpSv32) begin
            // No translation, page number passes straight through
            hit = 1'b1;
            needsUpdate = 1'b0;
            fault = 1'b0;
            ppn = Ppn'(vpn);
        end else begin
            needsUpdate = found && !selFault && (access == AccStore) && !selEntry.flags.dirty;
            hit = found && !needsUpdate;
            fault = found && selFault;
            ppn = selEntry.ppn;
        end
    end

endmodule

/* hw/TranslateCtrl.sv */
// Translation controller FSM
// Pops requests, runs the lookup, walks on a miss, pushes results

`timescale 1ns/10ps

module TranslateCtrl import MmuTypes::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        reqValid,
    input  TranslateReq reqData,
    output logic        reqPop,
    output Vpn          lookupVpn,
    output AccessType   lookupAccess,
    input  logic        hit,
    input  logic        needsUpdate,
    input  logic        fault,
    input  Ppn          ppn,
    input  TlbIndex     hitIndex,
    output logic        refill,
    output logic        replace,
    output TlbIndex     replaceIndex,
    output TlbEntry     refillEntry,
    output logic        walkReq,
    output Vpn          walkVpn,
    input  logic        pteValid,
    input  TlbEntry     pteEntry,
    output logic        rspPush,
    output TranslateRsp rspData,
    input  logic        rspFull
);
    typedef enum logic [1:0] {
        StIdle,
        StLookup,
        StWalk,
        StRespond
    } CtrlState;

    CtrlState    state;
    TranslateReq curReq;
    TranslateRsp result;
    TlbIndex     updateIndex;
    logic        isUpdate;
    // Refill sent, slot write still one cycle away
    logic        filling;

    assign reqPop = (state == StIdle) && reqValid;
    assign lookupVpn = curReq.vpn;
    assign lookupAccess = curReq.access;
    assign walkVpn = curReq.vpn;
    assign refill = (state == StWalk) && !filling && pteValid;
    assign replace = isUpdate;
    assign replaceIndex = updateIndex;
    assign refillEntry = pteEntry;
    assign rspPush = (state == StRespond) && !rspFull;
    assign rspData = result;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StIdle;
            walkReq <= 1'b0;
            isUpdate <= 1'b0;
            filling <= 1'b0;
        end else begin
            walkReq <= 1'b0;
            case (state)
                StIdle: begin
                    if (reqValid) begin
                        state <= StLookup;
                    end
                end
                StLookup: begin
                    // Faulting hits respond too
                    if (hit) begin
                        state <= StRespond;
                    end else begin
                        state <= StWalk;
                        walkReq <= 1'b1;
                        isUpdate <= needsUpdate;
                    end
                end
                StWalk: begin
                    if (filling) begin
                        filling <= 1'b0;
                        state <= StLookup;
                    end else if (pteValid) begin
                        filling <= 1'b1;
                    end
                end
                StRespond: begin
                    // Hold the result while the response queue is full
                    if (!rspFull) begin
                        state <= StIdle;
                    end
                end
                default: state <= StIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reqPop) begin
            curReq <= reqData;
        end
        if (state == StLookup) begin
            result.ppn <= ppn;
            result.fault <= fault;
            updateIndex <= hitIndex;
        end
    end

endmodule

/* hw/MmuTranslate.sv */
// Sv32 address translation unit, top level
// Request and response queues, controller, fill unit, TLB slots, lookup

`timescale 1ns/10ps

`include "mmu_cfg.svh"

module MmuTranslate import MmuTypes::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      reqValid,
    input  Vpn        reqVpn,
    input  AccessType reqAccess,
    output logic      reqCredit,
    output logic      rspValid,
    output Ppn        rspPpn,
    output logic      rspFault,
    input  logic      rspCredit,
    output logic      walkReq,
    output Vpn        walkVpn,
    input  logic      pteValid,
    input  TlbEntry   pteEntry,
    input  logic      satpSv32,
    input  Privilege  priv,
    input  logic      sum,
    input  logic      mxr,
    input  logic      flush
);
    TranslateReq reqIn;
    TranslateReq reqHead;
    logic        reqHeadValid;
    logic        reqPop;
    TranslateRsp rspIn;
    TranslateRsp rspOut;
    logic        rspPush;
    logic        rspFull;

    Vpn        lookupVpn;
    AccessType lookupAccess;
    logic      hit;
    logic      needsUpdate;
    logic      fault;
    Ppn        ppn;
    TlbIndex   hitIndex;

    logic    refill;
    logic    replace;
    TlbIndex replaceIndex;
    TlbEntry refillEntry;

    logic [`TLB_ENTRIES-1:0] slotWe;
    logic [`TLB_ENTRIES-1:0] slotMatch;
    TlbEntry                 slotEntries [`TLB_ENTRIES];
    Vpn                      wKey;
    TlbEntry                 wEntry;

    assign reqIn = '{vpn: reqVpn, access: reqAccess};
    assign rspPpn = rspOut.ppn;
    assign rspFault = rspOut.fault;

    // Local consumer hands its credit straight back on every pop
    CreditFifo #(
        .payload_t(TranslateReq),
        .DEPTH(`REQ_DEPTH),
        .OUT_CREDITS(`REQ_DEPTH)
    ) reqQ (
        .clk,
        .rst,
        .inValid(reqValid),
        .inData(reqIn),
        .inCredit(reqCredit),
        .full(),
        .outValid(reqHeadValid),
        .outData(reqHead),
        .outCredit(reqPop),
        .popReady(reqPop)
    );

    CreditFifo #(
        .payload_t(TranslateRsp),
        .DEPTH(`RSP_DEPTH),
        .OUT_CREDITS(`RSP_DEPTH)
    ) rspQ (
        .clk,
        .rst,
        .inValid(rspPush),
        .inData(rspIn),
        .inCredit(),
        .full(rspFull),
        .outValid(rspValid),
        .outData(rspOut),
        .outCredit(rspCredit),
        .popReady(1'b1)
    );

    TranslateCtrl ctrl (
        .clk,
        .rst,
        .reqValid(reqHeadValid),
        .reqData(reqHead),
        .reqPop,
        .lookupVpn,
        .lookupAccess,
        .hit,
        .needsUpdate,
        .fault,
        .ppn,
        .hitIndex,
        .refill,
        .replace,
        .replaceIndex,
        .refillEntry,
        .walkReq,
        .walkVpn,
        .pteValid,
        .pteEntry,
        .rspPush,
        .rspData(rspIn),
        .rspFull
    );

    TlbFill fill (
        .clk,
        .rst,
        .refill,
        .replace,
        .replaceIndex,
        .refillKey(lookupVpn),
        .refillEntry,
        .slotWe,
        .wKey,
        .wEntry
    );

    for (genvar i = 0; i < `TLB_ENTRIES; i++) begin : gSlot
        TlbEntrySlot slot (
            .clk,
            .rst,
            .flush,
            .we(slotWe[i]),
            .wKey,
            .wEntry,
            .lookupKey(lookupVpn),
            .match(slotMatch[i]),
            .entry(slotEntries[i])
        );
    end

    TlbLookup lookup (
        .match(slotMatch),
        .entries(slotEntries),
        .vpn(lookupVpn),
        .access(lookupAccess),
        .priv,
        .satpSv32,
        .sum,
        .mxr,
        .hit,
        .needsUpdate,
        .fault,
        .ppn,
        .hitIndex
    );

endmodule

/* sim/tb_mmu.sv */
// Testbench for the Sv32 translation unit
// Clock, reset, walker model, reference TLB model, stimulus and checks

`timescale 1ns/10ps

`include "mmu_cfg.svh"

module tb_mmu import MmuTypes::*; ();

    localparam int TimeoutCycles = 4000;
    localparam int MaxReqs = 512;

    logic      clk;
    logic      rst;
    logic      reqValid;
    Vpn        reqVpn;
    AccessType reqAccess;
    logic      reqCredit;
    logic      rspValid;
    Ppn        rspPpn;
    logic      rspFault;
    logic      rspCredit;
    logic      walkReq;
    Vpn        walkVpn;
    logic      pteValid;
    TlbEntry   pteEntry;
    logic      satpSv32;
    Privilege  priv;
    logic      sum;
    logic      mxr;
    logic      flush;

    // Page table shared by the walker and the reference model
    TlbEntry pteTable [Vpn];
    Vpn      pool [10];

    // Reference TLB with its own round-robin pointer
    logic    mValid [`TLB_ENTRIES];
    Vpn      mKey [`TLB_ENTRIES];
    TlbEntry mEnt [`TLB_ENTRIES];
    int      mVictim;

    Vpn        reqVpnLog [MaxReqs];
    AccessType reqAccLog [MaxReqs];
    Ppn        expPpn [MaxReqs];
    logic      expFault [MaxReqs];
    int        expWalks [MaxReqs];
    int        walkCount [MaxReqs];

    int sentCount;
    int popCount;
    int rspCount;
    int reqCredits;
    int mmuCredits;
    int held;
    int cycles;
    int seed = 32'h824d;
    int creditSeed = 32'h824d + 1;
    int walkSeed = 32'h824d + 2;

    MmuTranslate i_MmuTranslate (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task reportFailure();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task reportValue(string name, logic [31:0] expVal, logic [31:0] gotVal);
        $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expVal, gotVal);
        reportFailure();
    endtask

    function automatic TlbEntry makePte(logic r, logic w, logic x, logic u, logic d,
                                        logic f, Vpn v);
        TlbEntry e;
        e.valid = 1'b1;
        e.fault = f;
        e.flags = '{read: r, write: w, execute: x, user: u, dirty: d};
        e.ppn = Ppn'(v) ^ 22'h2a0000;
        return e;
    endfunction

    // A real walker sets the dirty bit when it serves a store
    function automatic TlbEntry walkResult(Vpn v, AccessType a);
        TlbEntry e;
        e = pteTable[v];
        if (a == AccStore) begin
            e.flags.dirty = 1'b1;
        end
        return e;
    endfunction

    function automatic logic ruleFault(TlbEntry e, AccessType a);
        logic bad;
        bad = e.fault;
        if (priv == PrivSupervisor && e.flags.user && !sum) begin
            bad = 1'b1;
        end
        if (priv == PrivUser && !e.flags.user) begin
            bad = 1'b1;
        end
        if (a == AccInstr && !e.flags.execute) begin
            bad = 1'b1;
        end
        if (a == AccLoad && !e.flags.read && !(mxr && e.flags.execute)) begin
            bad = 1'b1;
        end
        if (a == AccStore && !e.flags.write) begin
            bad = 1'b1;
        end
        return bad;
    endfunction

    // Expected result and walk count for request n
    task automatic predict(Vpn v, AccessType a, int n);
        int      idx;
        int      walks;
        TlbEntry e;
        logic    f;
        logic    done;
        walks = 0;
        done = 1'b0;
        if (!satpSv32 || priv == PrivMachine) begin
            expPpn[n] = Ppn'(v);
            expFault[n] = 1'b0;
            expWalks[n] = 0;
            return;
        end
        while (!done) begin
            idx = -1;
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                if (mValid[i] && mKey[i] == v) begin
                    idx = i;
                end
            end
            if (idx < 0) begin
                walks++;
                mValid[mVictim] = 1'b1;
                mKey[mVictim] = v;
                mEnt[mVictim] = walkResult(v, a);
                mVictim = (mVictim + 1) % `TLB_ENTRIES;
            end else begin
                e = mEnt[idx];
                f = ruleFault(e, a);
                if (!f && a == AccStore && !e.flags.dirty) begin
                    // Dirty update rewrites the same slot
                    walks++;
                    mEnt[idx] = walkResult(v, a);
                end else begin
                    expPpn[n] = e.ppn;
                    expFault[n] = f;
                    done = 1'b1;
                end
            end
        end
        expWalks[n] = walks;
    endtask

    task automatic sendReq(Vpn v, AccessType a);
        while (reqCredits == 0) begin
            @(posedge clk);
            #1;
        end
        reqVpnLog[sentCount] = v;
        reqAccLog[sentCount] = a;
        predict(v, a, sentCount);
        reqValid = 1'b1;
        reqVpn = v;
        reqAccess = a;
        reqCredits--;
        sentCount++;
        @(posedge clk);
        #1;
        reqValid = 1'b0;
    endtask

    task automatic waitDrain();
        while (rspCount != sentCount) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic setMode(logic s, Privilege p, logic su, logic m);
        waitDrain();
        satpSv32 = s;
        priv = p;
        sum = su;
        mxr = m;
    endtask

    task automatic pulseFlush();
        waitDrain();
        flush = 1'b1;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            mValid[i] = 1'b0;
        end
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    // Walks only happen with translation on
    walkModeCheck: assert property (@(posedge clk) disable iff (rst)
        walkReq |-> (satpSv32 && priv != PrivMachine))
        else begin
            $display("Walk request issued while translation is bypassed");
            reportFailure();
        end

    always @(posedge clk) begin
        if (!rst) begin
            if (reqCredit) begin
                popCount++;
                reqCredits++;
            end
            assert (popCount <= sentCount) else begin
                $display("Request credit returned with no request queued");
                reportFailure();
            end
            // A request sent on a held credit must find room in the queue
            assert (!(reqValid && i_MmuTranslate.reqQ.full)) else begin
                $display("Request dropped at %0t, request queue full", $time);
                reportFailure();
            end
            if (rspValid) begin
                assert (mmuCredits > 0) else begin
                    $display("Response sent without a response credit at %0t", $time);
                    reportFailure();
                end
                assert (rspCount < sentCount) else begin
                    $display("Response arrived with no request outstanding");
                    reportFailure();
                end
                assert (rspPpn == expPpn[rspCount])
                    else reportValue("rspPpn", 32'(expPpn[rspCount]), 32'(rspPpn));
                assert (rspFault == expFault[rspCount])
                    else reportValue("rspFault", 32'(expFault[rspCount]), 32'(rspFault));
                assert (walkCount[rspCount] == expWalks[rspCount])
                    else reportValue("walkCount", 32'(expWalks[rspCount]),
                                     32'(walkCount[rspCount]));
                rspCount++;
                held++;
                mmuCredits--;
            end
            if (rspCredit) begin
                mmuCredits++;
            end
        end
    end

    // Consumer returns its credits at random
    always @(posedge clk) begin
        #1;
        rspCredit = 1'b0;
        if (!rst && held > 0 && $random(creditSeed) % 2 == 0) begin
            rspCredit = 1'b1;
            held--;
        end
    end

    // Walker answers after 1 to 5 cycles
    initial begin
        int idx;
        int delay;
        forever begin
            @(posedge clk);
            if (!rst && walkReq) begin
                idx = popCount - 1;
                assert (walkVpn == reqVpnLog[idx])
                    else reportValue("walkVpn", 32'(reqVpnLog[idx]), 32'(walkVpn));
                walkCount[idx]++;
                delay = 1 + int'($unsigned($random(walkSeed)) % 5);
                repeat (delay - 1) @(posedge clk);
                #1;
                pteValid = 1'b1;
                pteEntry = walkResult(walkVpn, reqAccLog[idx]);
                @(posedge clk);
                #1;
                pteValid = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TimeoutCycles) begin
            $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
            reportFailure();
        end
    end

    initial begin
        int r;
        rst = 1'b1;
        reqValid = 1'b0;
        reqVpn = '0;
        reqAccess = AccLoad;
        rspCredit = 1'b0;
        pteValid = 1'b0;
        pteEntry = '0;
        satpSv32 = 1'b0;
        priv = PrivSupervisor;
        sum = 1'b0;
        mxr = 1'b0;
        flush = 1'b0;
        sentCount = 0;
        popCount = 0;
        rspCount = 0;
        reqCredits = `REQ_DEPTH;
        mmuCredits = `RSP_DEPTH;
        held = 0;
        cycles = 0;
        mVictim = 0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            mValid[i] = 1'b0;
        end
        for (int i = 0; i < MaxReqs; i++) begin
            walkCount[i] = 0;
        end
        // Kernel rw clean pages for eviction and dirty tests
        for (int i = 0; i < 5; i++) begin
            pteTable[Vpn'(20'h10 + i)] = makePte(1, 1, 0, 0, 0, 0, Vpn'(20'h10 + i));
            pool[i] = Vpn'(20'h10 + i);
        end
        pteTable[20'h20] = makePte(1, 1, 1, 1, 1, 0, 20'h20);
        pteTable[20'h21] = makePte(0, 0, 1, 0, 0, 0, 20'h21);
        pteTable[20'h22] = makePte(1, 0, 0, 0, 0, 0, 20'h22);
        pteTable[20'h23] = makePte(1, 1, 1, 0, 1, 1, 20'h23);
        pteTable[20'h24] = makePte(1, 0, 0, 1, 0, 0, 20'h24);
        for (int i = 0; i < 5; i++) begin
            pool[5 + i] = Vpn'(20'h20 + i);
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // Bare mode, then machine mode
        for (int i = 0; i < 12; i++) begin
            if (i == 6) begin
                setMode(1'b1, PrivMachine, 1'b0, 1'b0);
            end
            r = $random(seed);
            sendReq(Vpn'(r), AccessType'(2'($unsigned(r) % 3)));
        end

        // Five pages through four slots
        setMode(1'b1, PrivSupervisor, 1'b0, 1'b0);
        sendReq(20'h10, AccLoad);
        sendReq(20'h11, AccLoad);
        sendReq(20'h12, AccLoad);
        sendReq(20'h13, AccLoad);
        sendReq(20'h10, AccLoad);
        sendReq(20'h14, AccLoad);
        sendReq(20'h10, AccLoad);

        // Permission faults
        sendReq(20'h20, AccLoad);
        sendReq(20'h21, AccLoad);
        sendReq(20'h22, AccInstr);
        sendReq(20'h22, AccLoad);
        sendReq(20'h22, AccStore);
        sendReq(20'h23, AccLoad);
        sendReq(20'h21, AccInstr);
        setMode(1'b1, PrivSupervisor, 1'b1, 1'b1);
        sendReq(20'h20, AccLoad);
        sendReq(20'h21, AccLoad);
        setMode(1'b1, PrivUser, 1'b0, 1'b0);
        sendReq(20'h24, AccLoad);
        sendReq(20'h22, AccLoad);
        sendReq(20'h20, AccInstr);

        // Dirty update on a resident clean page
        setMode(1'b1, PrivSupervisor, 1'b0, 1'b0);
        sendReq(20'h11, AccLoad);
        sendReq(20'h11, AccStore);
        sendReq(20'h11, AccLoad);
        sendReq(20'h23, AccLoad);

        pulseFlush();
        sendReq(20'h11, AccLoad);
        sendReq(20'h23, AccLoad);
        sendReq(20'h24, AccLoad);
        sendReq(20'h20, AccInstr);

        // Random traffic in random modes
        for (int b = 0; b < 6; b++) begin
            r = $random(seed);
            setMode(1'b1, r[0] ? PrivUser : PrivSupervisor, r[1], r[2]);
            for (int i = 0; i < 20; i++) begin
                r = $random(seed);
                sendReq(pool[$unsigned(r) % 10], AccessType'(2'($unsigned(r >> 8) % 3)));
            end
        end
        waitDrain();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* src.f */
+incdir+include
hw/MmuTypes.sv
hw/CreditFifo.sv
hw/TlbEntrySlot.sv
hw/TlbFill.sv
hw/TlbLookup.sv
hw/TranslateCtrl.sv
hw/MmuTranslate.sv
sim/tb_mmu.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the translation unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_mmu
if [ $? -ne 0 ]; then
    echo "Compilation failed"
    exit 1
fi

output=$(./obj_dir/Vtb_mmu 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1
